//--- common/cpu_defines.svh
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// Datapath word
// Also the address width of both memories
`define CPU_WORD_SIZE 16

// Four architectural registers
`define CPU_REG_BITS 2

// Instruction field widths
`define CPU_OPCODE_BITS 4
`define CPU_FUNC_BITS 6

// Low byte immediate, sign-extended in decode
`define CPU_IMM_BITS 8

`endif

//--- common/isa_pkg.sv
`include "cpu_defines.svh"

package isa_pkg;

   // Data word, address or instruction
   typedef logic [`CPU_WORD_SIZE-1:0] word_t;

   // Register number
   typedef logic [`CPU_REG_BITS-1:0] reg_idx_t;

   // Major opcodes in the top nibble
   // Anything not listed decodes as a nop
   typedef enum logic [`CPU_OPCODE_BITS-1:0] {
      ADI   = 4'd4,
      LHI   = 4'd6,
      LWD   = 4'd7,
      SWD   = 4'd8,
      RTYPE = 4'd15
   } opcode_e;

   // Function codes under RTYPE
   typedef enum logic [`CPU_FUNC_BITS-1:0] {
      ADD = 6'd0,
      SUB = 6'd1,
      AND = 6'd2,
      ORR = 6'd3,
      WWD = 6'd28,
      HLT = 6'd29
   } func_e;

endpackage

//--- common/pipe_pkg.sv
package pipe_pkg;

   // Where an execute operand comes from
   typedef enum logic [1:0] {
      FROM_RF,
      FROM_MEM,
      FROM_WB
   } fwd_src_e;

   // Register write-back value, WB_IMM for LHI
   typedef enum logic [1:0] {
      WB_ALU,
      WB_MEM,
      WB_IMM
   } wb_src_e;

   typedef enum logic [1:0] {ALU_ADD, ALU_SUB, ALU_AND, ALU_ORR} alu_op_e;

endpackage

//--- src/inst_decoder.sv
`timescale 1ns/1ps

`include "cpu_defines.svh"

module inst_decoder import isa_pkg::*, pipe_pkg::*; (
   input  word_t    i_inst,
   output reg_idx_t o_rs,
   output reg_idx_t o_rt,
   output reg_idx_t o_dest,
   output word_t    o_imm,
   output alu_op_e  o_alu_op,
   output logic     o_use_imm,
   output logic     o_reg_write,
   output wb_src_e  o_wb_src,
   output logic     o_mem_read,
   output logic     o_mem_write,
   output logic     o_output_write,
   output logic     o_halt,
   output logic     o_uses_rt
);

   // Register fields packed below the opcode
   localparam int rs_lsb = `CPU_WORD_SIZE - `CPU_OPCODE_BITS - `CPU_REG_BITS;
   localparam int rt_lsb = rs_lsb - `CPU_REG_BITS;
   localparam int rd_lsb = rt_lsb - `CPU_REG_BITS;

   opcode_e  opcode;
   func_e    func;
   reg_idx_t rd;

   assign opcode = opcode_e'(i_inst[`CPU_WORD_SIZE-1 -: `CPU_OPCODE_BITS]);
   assign func   = func_e'(i_inst[`CPU_FUNC_BITS-1:0]);
   assign o_rs   = i_inst[rs_lsb +: `CPU_REG_BITS];
   assign o_rt   = i_inst[rt_lsb +: `CPU_REG_BITS];
   assign rd     = i_inst[rd_lsb +: `CPU_REG_BITS];

   // Sign-extend low byte
   assign o_imm = {{(`CPU_WORD_SIZE - `CPU_IMM_BITS){i_inst[`CPU_IMM_BITS-1]}},
                   i_inst[`CPU_IMM_BITS-1:0]};

   always_comb begin
      // Nop unless claimed below
      o_dest         = o_rt;
      o_alu_op       = ALU_ADD;
      o_use_imm      = 1'b0;
      o_reg_write    = 1'b0;
      o_wb_src       = WB_ALU;
      o_mem_read     = 1'b0;
      o_mem_write    = 1'b0;
      o_output_write = 1'b0;
      o_halt         = 1'b0;
      o_uses_rt      = 1'b0;
      case (opcode)
         ADI: begin
            o_use_imm   = 1'b1;
            o_reg_write = 1'b1;
         end
         // Upper-byte constant, value built later from the immediate
         LHI: begin
            o_reg_write = 1'b1;
            o_wb_src    = WB_IMM;
         end
         // Address is rs plus immediate
         LWD: begin
            o_use_imm   = 1'b1;
            o_reg_write = 1'b1;
            o_wb_src    = WB_MEM;
            o_mem_read  = 1'b1;
         end
         // rt carries the store data
         SWD: begin
            o_use_imm   = 1'b1;
            o_mem_write = 1'b1;
            o_uses_rt   = 1'b1;
         end
         RTYPE: begin
            case (func)
               ADD: o_alu_op = ALU_ADD;
               SUB: o_alu_op = ALU_SUB;
               AND: o_alu_op = ALU_AND;
               ORR: o_alu_op = ALU_ORR;
               WWD: o_output_write = 1'b1;
               HLT: o_halt = 1'b1;
               default: ;
            endcase
            // ALU group writes rd from rs and rt
            if (func inside {ADD, SUB, AND, ORR}) begin
               o_dest      = rd;
               o_reg_write = 1'b1;
               o_uses_rt   = 1'b1;
            end
         end
         default: ;
      endcase
   end

endmodule

//--- src/register_file.sv
`timescale 1ns/1ps

module register_file import isa_pkg::*; (
   input  logic     clk,
   input  logic     reset_n,
   input  reg_idx_t i_read_a,
   input  reg_idx_t i_read_b,
   input  logic     i_write,
   input  reg_idx_t i_write_idx,
   input  word_t    i_write_data,
   output word_t    o_data_a,
   output word_t    o_data_b
);

   localparam int num_regs = 2 ** $bits(reg_idx_t);

   word_t regs [num_regs];

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         for (int i = 0; i < num_regs; i++) begin
            regs[i] <= '0;
         end
      end else if (i_write) begin
         regs[i_write_idx] <= i_write_data;
      end
   end

   // Write-through, decode sees the value retiring this cycle
   assign o_data_a = (i_write && i_write_idx == i_read_a) ? i_write_data : regs[i_read_a];
   assign o_data_b = (i_write && i_write_idx == i_read_b) ? i_write_data : regs[i_read_b];

   // Write-back must always name a register
   a_write_idx_known: assert property (@(posedge clk) disable iff (!reset_n)
      i_write |-> !$isunknown(i_write_idx));

endmodule

//--- src/hazard_unit.sv
`timescale 1ns/1ps

module hazard_unit import isa_pkg::*; (
   input  reg_idx_t i_rs_id,
   input  reg_idx_t i_rt_id,
   input  logic     i_uses_rt_id,
   input  logic     i_load_ex,
   input  reg_idx_t i_dest_ex,
   input  logic     i_halt_id,
   output logic     o_stall,
   output logic     o_halt_fetch
);

   logic rs_hit;
   logic rt_hit;

   ////////////////////////////////
   // Load-use
   ////////////////////////////////

   // rs treated as always read
   assign rs_hit = (i_dest_ex == i_rs_id);
   assign rt_hit = i_uses_rt_id && (i_dest_ex == i_rt_id);

   // Load data only exists in write-back
   // so the very next instruction waits one slot
   assign o_stall = i_load_ex && (rs_hit || rt_hit);

   ////////////////////////////////
   // Halt
   ////////////////////////////////

   // HLT held by a stall has not left decode yet
   assign o_halt_fetch = i_halt_id && !o_stall;

endmodule

//--- src/forwarding_unit.sv
`timescale 1ns/1ps

module forwarding_unit import isa_pkg::*, pipe_pkg::*; (
   input  reg_idx_t i_rs_ex,
   input  reg_idx_t i_rt_ex,
   input  logic     i_reg_write_mem,
   input  reg_idx_t i_dest_mem,
   input  logic     i_reg_write_wb,
   input  reg_idx_t i_dest_wb,
   output fwd_src_e o_fwd_a,
   output fwd_src_e o_fwd_b
);

   // Newest producer first
   function automatic fwd_src_e pick_src(reg_idx_t src);
      if (i_reg_write_mem && i_dest_mem == src) begin
         return FROM_MEM;
      end else if (i_reg_write_wb && i_dest_wb == src) begin
         return FROM_WB;
      end
      return FROM_RF;
   endfunction

   always_comb begin
      o_fwd_a = pick_src(i_rs_ex);
      o_fwd_b = pick_src(i_rt_ex);
      // Memory stage only counts when it writes
      a_mem_live: assert (i_reg_write_mem || (o_fwd_a != FROM_MEM && o_fwd_b != FROM_MEM))
         else $error("memory-stage forward without a register write");
   end

endmodule

//--- core/cpu_core.sv
`timescale 1ns/1ps

`include "cpu_defines.svh"

module cpu_core import isa_pkg::*, pipe_pkg::*; (
   input  logic  clk,
   input  logic  reset_n,
   input  word_t i_i_data,
   input  word_t i_d_data,
   output word_t o_i_address,
   output logic  o_i_read,
   output word_t o_d_address,
   output word_t o_d_data,
   output logic  o_d_read,
   output logic  o_d_write,
   output word_t o_output_port,
   output logic  o_output_write,
   output logic  o_halted,
   output word_t o_num_inst
);

   // Fetch and decode
   word_t    pc, ir;
   logic     valid_id, fetch_halted, fetch_stop;
   reg_idx_t dec_rs, dec_rt, dec_dest;
   word_t    dec_imm, rf_a, rf_b;
   alu_op_e  dec_alu_op;
   wb_src_e  dec_wb_src;
   logic     dec_use_imm, dec_reg_write, dec_mem_read, dec_mem_write;
   logic     dec_output_write, dec_halt, dec_uses_rt;
   logic     halt_id, stall, halt_fetch, bubble;
   // Execute
   logic     valid_ex, reg_write_ex, mem_read_ex, mem_write_ex;
   logic     output_write_ex, halt_ex, use_imm_ex;
   wb_src_e  wb_src_ex;
   alu_op_e  alu_op_ex;
   reg_idx_t rs_ex, rt_ex, dest_ex;
   word_t    a_ex, b_ex, imm_ex, opnd_a, opnd_b, alu_b, alu_out;
   fwd_src_e fwd_a, fwd_b;
   // Memory and write-back
   logic     valid_mem, reg_write_mem, mem_read_mem, mem_write_mem, halt_mem;
   logic     valid_wb, reg_write_wb;
   wb_src_e  wb_src_mem, wb_src_wb;
   reg_idx_t dest_mem, dest_wb;
   word_t    alu_mem, store_mem, lhi_mem, mem_fwd, alu_wb, mdr_wb, lhi_wb, wb_data;

   function automatic word_t pick_operand(fwd_src_e sel, word_t rf_val, word_t mem_val,
                                          word_t wb_val);
      case (sel)
         FROM_MEM: return mem_val;
         FROM_WB:  return wb_val;
         default:  return rf_val;
      endcase
   endfunction

   //////////////////////////////
   // Fetch and decode
   //////////////////////////////

   // Nops only once HLT has left decode
   assign fetch_stop  = halt_fetch || fetch_halted;
   assign o_i_address = pc;
   assign o_i_read    = !fetch_stop;

   inst_decoder decoder_i (
      .i_inst(ir), .o_rs(dec_rs), .o_rt(dec_rt), .o_dest(dec_dest), .o_imm(dec_imm),
      .o_alu_op(dec_alu_op), .o_use_imm(dec_use_imm), .o_reg_write(dec_reg_write),
      .o_wb_src(dec_wb_src), .o_mem_read(dec_mem_read), .o_mem_write(dec_mem_write),
      .o_output_write(dec_output_write), .o_halt(dec_halt), .o_uses_rt(dec_uses_rt)
   );

   register_file rf_i (
      .clk(clk), .reset_n(reset_n), .i_read_a(dec_rs), .i_read_b(dec_rt),
      .i_write(reg_write_wb), .i_write_idx(dest_wb), .i_write_data(wb_data),
      .o_data_a(rf_a), .o_data_b(rf_b)
   );

   assign halt_id = dec_halt && valid_id;

   hazard_unit hazard_i (
      .i_rs_id(dec_rs), .i_rt_id(dec_rt), .i_uses_rt_id(dec_uses_rt),
      .i_load_ex(mem_read_ex), .i_dest_ex(dest_ex), .i_halt_id(halt_id),
      .o_stall(stall), .o_halt_fetch(halt_fetch)
   );

   // Empty decode slot or load-use hold
   assign bubble = stall || !valid_id;

   //////////////////////////////
   // Execute
   //////////////////////////////

   forwarding_unit fwd_i (
      .i_rs_ex(rs_ex), .i_rt_ex(rt_ex), .i_reg_write_mem(reg_write_mem),
      .i_dest_mem(dest_mem), .i_reg_write_wb(reg_write_wb), .i_dest_wb(dest_wb),
      .o_fwd_a(fwd_a), .o_fwd_b(fwd_b)
   );

   // LHI result is ready in memory stage too
   assign mem_fwd = (wb_src_mem == WB_IMM) ? lhi_mem : alu_mem;
   assign opnd_a  = pick_operand(fwd_a, a_ex, mem_fwd, wb_data);
   assign opnd_b  = pick_operand(fwd_b, b_ex, mem_fwd, wb_data);
   assign alu_b   = use_imm_ex ? imm_ex : opnd_b;

   always_comb begin
      case (alu_op_ex)
         ALU_SUB: alu_out = opnd_a - alu_b;
         ALU_AND: alu_out = opnd_a & alu_b;
         ALU_ORR: alu_out = opnd_a | alu_b;
         default: alu_out = opnd_a + alu_b;
      endcase
   end

   //////////////////////////////
   // Memory and write-back
   //////////////////////////////

   assign o_d_address = alu_mem;
   assign o_d_data    = store_mem;
   assign o_d_read    = mem_read_mem;
   assign o_d_write   = mem_write_mem;

   always_comb begin
      case (wb_src_wb)
         WB_MEM:  wb_data = mdr_wb;
         WB_IMM:  wb_data = lhi_wb;
         default: wb_data = alu_wb;
      endcase
   end

   // Control state, bubbles zero the execute levels
   always_ff @(posedge clk) begin
      if (!reset_n) begin
         pc <= '0;
         ir <= '0;
         valid_id <= 1'b0;
         fetch_halted <= 1'b0;
         {valid_ex, reg_write_ex, mem_read_ex, mem_write_ex} <= '0;
         {output_write_ex, halt_ex, use_imm_ex} <= '0;
         wb_src_ex <= WB_ALU;
         alu_op_ex <= ALU_ADD;
         {valid_mem, reg_write_mem, mem_read_mem, mem_write_mem, halt_mem} <= '0;
         wb_src_mem <= WB_ALU;
         {valid_wb, reg_write_wb} <= '0;
         wb_src_wb <= WB_ALU;
         o_output_port <= '0;
         o_output_write <= 1'b0;
         o_halted <= 1'b0;
         o_num_inst <= '0;
      end else begin
         // Stall holds PC and IR
         if (!stall && !fetch_stop) begin
            pc <= pc + word_t'(1);
         end
         if (!stall) begin
            ir <= fetch_stop ? '0 : i_i_data;
            valid_id <= !fetch_stop;
         end
         fetch_halted <= fetch_halted || halt_fetch;
         // Decode to execute
         valid_ex        <= !bubble;
         reg_write_ex    <= !bubble && dec_reg_write;
         mem_read_ex     <= !bubble && dec_mem_read;
         mem_write_ex    <= !bubble && dec_mem_write;
         output_write_ex <= !bubble && dec_output_write;
         halt_ex         <= !bubble && dec_halt;
         use_imm_ex      <= !bubble && dec_use_imm;
         wb_src_ex       <= bubble ? WB_ALU : dec_wb_src;
         alu_op_ex       <= bubble ? ALU_ADD : dec_alu_op;
         // Execute to memory
         {valid_mem, reg_write_mem, halt_mem} <= {valid_ex, reg_write_ex, halt_ex};
         {mem_read_mem, mem_write_mem} <= {mem_read_ex, mem_write_ex};
         wb_src_mem <= wb_src_ex;
         // Memory to write-back
         {valid_wb, reg_write_wb} <= {valid_mem, reg_write_mem};
         wb_src_wb <= wb_src_mem;
         // WWD takes the forwarded rs
         if (output_write_ex) begin
            o_output_port <= opnd_a;
         end
         o_output_write <= output_write_ex;
         // Sticky once HLT enters write-back
         o_halted <= o_halted || halt_mem;
         if (valid_wb) begin
            o_num_inst <= o_num_inst + word_t'(1);
         end
      end
   end

   // Payload
   always_ff @(posedge clk) begin
      {rs_ex, rt_ex, dest_ex} <= {dec_rs, dec_rt, dec_dest};
      {imm_ex, a_ex, b_ex} <= {dec_imm, rf_a, rf_b};
      {alu_mem, store_mem, dest_mem} <= {alu_out, opnd_b, dest_ex};
      // Immediate into the upper byte
      lhi_mem <= {imm_ex[`CPU_IMM_BITS-1:0], {(`CPU_WORD_SIZE - `CPU_IMM_BITS){1'b0}}};
      {alu_wb, mdr_wb, lhi_wb, dest_wb} <= {alu_mem, i_d_data, lhi_mem, dest_mem};
   end

   // One data memory command per cycle
   a_mem_excl: assert property (@(posedge clk) disable iff (!reset_n)
      !(o_d_read && o_d_write));

   // Nothing reaches the output port after the drain
   a_quiet_halt: assert property (@(posedge clk) disable iff (!reset_n)
      o_halted |-> !o_output_write);

endmodule

//--- testbench/tb_programs.svh
`ifndef TB_PROGRAMS_SVH
`define TB_PROGRAMS_SVH

// One row per test program
// Image starts at address 0 and is padded with zeros
// Retire count covers every instruction up to and including HLT

localparam int num_progs = 4;

localparam int prog_len [num_progs] = '{12, 8, 9, 9};

localparam word_t prog_words [num_progs][16] = '{
   // Dependent ALU chains through MEM, WB and register write-through
   // ADI ADI ADD SUB WWD AND ORR WWD ADI WWD HLT
   // Trailing WWD past HLT must never issue
   '{16'h4105, 16'h4603, 16'hf6c0, 16'hfe41, 16'hf41c, 16'hfd82, 16'hfb03, 16'hf01c,
     16'h43fe, 16'hfc1c, 16'hf01d, 16'hf01c, 16'h0000, 16'h0000, 16'h0000, 16'h0000},
   // LHI into ADI from MEM, then from WB two slots later
   '{16'h6212, 16'h4a34, 16'hf81c, 16'h6180, 16'h4001, 16'h47ff, 16'hfc1c, 16'hf01d,
     16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000},
   // Store to 0x12, reload, WWD the loaded word
   '{16'h4110, 16'h62ab, 16'h4a55, 16'h8602, 16'h4312, 16'h7c00, 16'h4501, 16'hf01c,
     16'hf01d, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000},
   // Two load-use stalls, on an ADD and on a WWD
   '{16'h4120, 16'h42f9, 16'h8600, 16'h7700, 16'hfd00, 16'hf01c, 16'h7600, 16'hf81c,
     16'hf01d, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000}
};

// WWD values in program order
localparam word_t exp_out [num_progs][4] = '{
   '{16'h0005, 16'h000d, 16'h000b, 16'h0000},
   '{16'h1234, 16'h7fff, 16'h0000, 16'h0000},
   '{16'hab55, 16'h0000, 16'h0000, 16'h0000},
   '{16'h0019, 16'hfff9, 16'h0000, 16'h0000}
};
localparam int exp_out_count [num_progs] = '{3, 2, 1, 2};
localparam word_t exp_retire [num_progs] = '{16'd11, 16'd8, 16'd9, 16'd9};

// Data memory word left behind by SWD
localparam bit store_check [num_progs] = '{1'b0, 1'b0, 1'b1, 1'b1};
localparam word_t store_addr [num_progs] = '{16'h0000, 16'h0000, 16'h0012, 16'h0020};
localparam word_t store_data [num_progs] = '{16'h0000, 16'h0000, 16'hab55, 16'hfff9};

`endif

//--- testbench/tb_cpu.sv
`timescale 1ns/1ps

`include "cpu_defines.svh"

module tb_cpu import isa_pkg::*; ();

   `include "tb_programs.svh"

   logic  clk;
   logic  reset_n;
   word_t i_i_data, i_d_data, o_i_address, o_d_address, o_d_data;
   word_t o_output_port, o_num_inst;
   logic  o_i_read, o_d_read, o_d_write, o_output_write, o_halted;
   int    errors;
   int    checks;

   // 2-state, so both memories read zero before the first load
   bit [`CPU_WORD_SIZE-1:0] imem [256];
   bit [`CPU_WORD_SIZE-1:0] dmem [256];

   cpu_core dut_i (
      .clk(clk), .reset_n(reset_n), .i_i_data(i_i_data), .i_d_data(i_d_data),
      .o_i_address(o_i_address), .o_i_read(o_i_read), .o_d_address(o_d_address),
      .o_d_data(o_d_data), .o_d_read(o_d_read), .o_d_write(o_d_write),
      .o_output_port(o_output_port), .o_output_write(o_output_write),
      .o_halted(o_halted), .o_num_inst(o_num_inst)
   );

   initial begin
      clk = 1'b0;
      forever begin
         #2 clk = ~clk;
      end
   end

   //////////////////////////////
   // Memory models
   //////////////////////////////

   // Same-cycle answers
   assign i_i_data = imem[o_i_address[7:0]];
   assign i_d_data = dmem[o_d_address[7:0]];

   // Cleared while reset is low
   always @(posedge clk) begin
      if (!reset_n) begin
         for (int i = 0; i < 256; i++) begin
            dmem[i] <= '0;
         end
      end else if (o_d_write) begin
         dmem[o_d_address[7:0]] <= o_d_data;
      end
   end

   //////////////////////////////
   // Checks and sequencing
   //////////////////////////////

   task automatic check_value(input string name, input word_t exp, input word_t act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, act);
      end
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("** Error at %0t: %s expected %b, got %b", $time, name, exp, act);
      end
   endtask

   // Outputs of a core that has done nothing yet
   task automatic check_idle();
      check_bit("o_i_read", 1'b1, o_i_read);
      check_bit("o_d_read", 1'b0, o_d_read);
      check_bit("o_d_write", 1'b0, o_d_write);
      check_bit("o_output_write", 1'b0, o_output_write);
      check_bit("o_halted", 1'b0, o_halted);
      check_value("o_output_port", '0, o_output_port);
      check_value("o_num_inst", '0, o_num_inst);
   endtask

   task automatic load_program(input int p);
      for (int a = 0; a < 256; a++) begin
         imem[a] = '0;
      end
      for (int a = 0; a < prog_len[p]; a++) begin
         imem[a] = prog_words[p][a];
      end
   endtask

   // Ten reset cycles, then one more with the core free
   task automatic apply_reset();
      @(posedge clk);
      #1;
      reset_n = 1'b0;
      repeat (10) begin
         @(posedge clk);
         #1;
         check_idle();
      end
      reset_n = 1'b1;
      @(posedge clk);
      #1;
      check_idle();
   endtask

   task automatic run_program(input int p);
      int n_out;
      int settle;
      bit seen_halt;
      n_out = 0;
      settle = 0;
      seen_halt = 1'b0;
      load_program(p);
      apply_reset();
      // Run to the halt, then watch a few drained cycles
      while (settle < 5) begin
         @(posedge clk);
         #1;
         if (o_output_write) begin
            if (o_halted) begin
               errors++;
               $display("Program %0d pulsed o_output_write after the halt", p);
            end else if (n_out >= exp_out_count[p]) begin
               errors++;
               $display("Program %0d pulsed o_output_write too often", p);
            end else begin
               check_value("o_output_port", exp_out[p][n_out], o_output_port);
            end
            n_out++;
         end
         // Halt is sticky
         // Fetch stays frozen one word past HLT
         if (seen_halt) begin
            check_bit("o_halted", 1'b1, o_halted);
            check_bit("o_i_read", 1'b0, o_i_read);
            check_value("o_i_address", exp_retire[p], o_i_address);
            settle++;
         end
         seen_halt = seen_halt || o_halted;
      end
      checks++;
      if (n_out != exp_out_count[p]) begin
         errors++;
         $display("Program %0d gave %0d WWD pulses instead of %0d", p, n_out,
                  exp_out_count[p]);
      end
      check_value("o_num_inst", exp_retire[p], o_num_inst);
      if (store_check[p]) begin
         check_value("dmem", store_data[p], dmem[store_addr[p][7:0]]);
      end
   endtask

   initial begin
      reset_n = 1'b0;
      errors = 0;
      checks = 0;
      for (int p = 0; p < num_progs; p++) begin
         run_program(p);
      end
      $display("Ran %0d programs with %0d checks and %0d errors", num_progs, checks, errors);
      if (errors == 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

   // Budget per program is reset plus three cycles a word plus slack
   initial begin : watchdog
      int limit;
      int cycles;
      limit = 0;
      for (int p = 0; p < num_progs; p++) begin
         limit += 10 + 3 * prog_len[p] + 20;
      end
      cycles = 0;
      while (cycles < limit) begin
         @(posedge clk);
         cycles++;
      end
      $display("Timeout after %0d cycles, a program never finished", cycles);
      $display("Errors found");
      $finish;
   end

endmodule

//--- sources.f
+incdir+common
+incdir+testbench
common/isa_pkg.sv
common/pipe_pkg.sv
src/inst_decoder.sv
src/register_file.sv
src/hazard_unit.sv
src/forwarding_unit.sv
core/cpu_core.sv
testbench/tb_cpu.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the CPU testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_cpu -f sources.f -Mdir obj_dir \
   && ./obj_dir/Vtb_cpu > sim.log 2>&1 \
   || { cat sim.log 2>/dev/null; echo "Build or simulation failed"; exit 1; }
cat sim.log
grep -q "Errors found" sim.log && { echo "Simulation FAILED"; exit 1; }
grep -q "No errors" sim.log || { echo "Log has no pass line"; exit 1; }
echo "Simulation passed"
